//--- verilog/husky_pkg.sv
package husky_pkg;

   // register bus
   localparam int REG_ADDR_W        = 8;
   localparam int REG_DATA_W        = 8;

   // shared capture FIFO
   localparam int FIFO_WORD_W       = 18;
   localparam int FIFO_DEPTH        = 16;
   localparam int FIFO_PTR_W        = 4;

   // error flash on the red LEDs
   localparam int FLASH_HALF_PERIOD = 8;
   localparam int FLASH_CNT_W       = $clog2(FLASH_HALF_PERIOD);

   // register map
   localparam logic [REG_ADDR_W-1:0] ADCREAD_ADDR      = 8'd3;  // stream, bypasses the read register
   localparam logic [REG_ADDR_W-1:0] TARGET_CTRL_ADDR  = 8'd4;
   localparam logic [REG_ADDR_W-1:0] TARGET_OUT_ADDR   = 8'd5;
   localparam logic [REG_ADDR_W-1:0] CAPTURE_CTRL_ADDR = 8'd6;
   localparam logic [REG_ADDR_W-1:0] FIFO_STATUS_ADDR  = 8'd7;  // read only

   // TARGET_CTRL bits
   localparam int TC_POWER_OFF_BIT  = 0;
   localparam int TC_AVRPROG_BIT    = 1;
   localparam int TC_DEBUG_BIT      = 2;
   localparam int TC_SWD_BIT        = 3;

   // TARGET_OUT bits
   localparam int TO_NRST_EN_BIT    = 0;
   localparam int TO_NRST_VAL_BIT   = 1;
   localparam int TO_PDID_EN_BIT    = 2;
   localparam int TO_PDID_VAL_BIT   = 3;
   localparam int TO_PDIC_EN_BIT    = 4;
   localparam int TO_PDIC_VAL_BIT   = 5;

   // CAPTURE_CTRL bits
   localparam int CC_TRACE_ON_BIT   = 0;
   localparam int CC_CLEAR_ERR_BIT  = 1;  // write-1 pulse, reads 0

   // FIFO_STATUS bits
   localparam int FS_EMPTY_BIT      = 0;
   localparam int FS_FULL_BIT       = 1;
   localparam int FS_OVERFLOW_BIT   = 2;

endpackage

//--- verilog/ctrl_regs.sv
`timescale 1ns/100ps

module ctrl_regs (
   input  logic                              clk_usb_buf,
   input  logic                              reset_i,
   input  logic [husky_pkg::REG_ADDR_W-1:0]  reg_address_i,
   input  logic [husky_pkg::REG_DATA_W-1:0]  reg_write_data_i,
   input  logic                              reg_read_i,
   input  logic                              reg_write_i,
   output logic [husky_pkg::REG_DATA_W-1:0]  readback_o,
   output logic                              target_power_off_o,
   output logic                              enable_avrprog_o,
   output logic                              target_debug_o,
   output logic                              target_debug_swd_o,
   output logic                              nrst_en_o,
   output logic                              nrst_val_o,
   output logic                              pdid_en_o,
   output logic                              pdid_val_o,
   output logic                              pdic_en_o,
   output logic                              pdic_val_o,
   output logic                              trace_capture_on_o,
   output logic                              clear_errors_o
);
   import husky_pkg::*;

   logic [REG_DATA_W-1:0] target_ctrl;
   logic [REG_DATA_W-1:0] target_out;
   logic                  trace_on;

   // register writes, value applies from the next cycle
   always_ff @(posedge clk_usb_buf) begin
      if (reset_i) begin
         target_ctrl    <= REG_DATA_W'(1) << TC_POWER_OFF_BIT;  // target starts unpowered
         target_out     <= '0;
         trace_on       <= 1'b0;
         clear_errors_o <= 1'b0;
      end else begin
         clear_errors_o <= 1'b0;
         if (reg_write_i) begin
            case (reg_address_i)
               TARGET_CTRL_ADDR: target_ctrl <= reg_write_data_i;
               TARGET_OUT_ADDR:  target_out  <= reg_write_data_i;
               CAPTURE_CTRL_ADDR: begin
                  trace_on       <= reg_write_data_i[CC_TRACE_ON_BIT];
                  clear_errors_o <= reg_write_data_i[CC_CLEAR_ERR_BIT];  // one-cycle pulse
               end
               default: ;
            endcase
         end
      end
   end

   // readback is zero unless one of our addresses is being read
   always_comb begin
      readback_o = '0;
      if (reg_read_i) begin
         case (reg_address_i)
            TARGET_CTRL_ADDR:  readback_o = target_ctrl;
            TARGET_OUT_ADDR:   readback_o = target_out;
            CAPTURE_CTRL_ADDR: readback_o[CC_TRACE_ON_BIT] = trace_on;  // clear bit reads 0
            default:           readback_o = '0;
         endcase
      end
   end

   assign target_power_off_o = target_ctrl[TC_POWER_OFF_BIT];
   assign enable_avrprog_o   = target_ctrl[TC_AVRPROG_BIT];
   assign target_debug_o     = target_ctrl[TC_DEBUG_BIT];
   assign target_debug_swd_o = target_ctrl[TC_SWD_BIT];

   assign nrst_en_o          = target_out[TO_NRST_EN_BIT];
   assign nrst_val_o         = target_out[TO_NRST_VAL_BIT];
   assign pdid_en_o          = target_out[TO_PDID_EN_BIT];
   assign pdid_val_o         = target_out[TO_PDID_VAL_BIT];
   assign pdic_en_o          = target_out[TO_PDIC_EN_BIT];
   assign pdic_val_o         = target_out[TO_PDIC_VAL_BIT];

   assign trace_capture_on_o = trace_on;

endmodule

//--- verilog/read_data_mux.sv
`timescale 1ns/100ps

module read_data_mux (
   input  logic                              clk_usb_buf,
   input  logic                              reset_i,
   input  logic [husky_pkg::REG_ADDR_W-1:0]  reg_address_i,
   input  logic [husky_pkg::REG_DATA_W-1:0]  ctrl_readback_i,
   input  logic [husky_pkg::REG_DATA_W-1:0]  fifo_readback_i,
   input  logic [husky_pkg::REG_DATA_W-1:0]  adc_stream_data_i,
   output logic [husky_pkg::REG_DATA_W-1:0]  read_data_o
);
   import husky_pkg::*;

   logic [REG_DATA_W-1:0] read_data_reg;

   // idle blocks return zero, so a plain OR selects the active one
   always_ff @(posedge clk_usb_buf) begin
      if (reset_i) begin
         read_data_reg <= '0;
      end else begin
         read_data_reg <= ctrl_readback_i | fifo_readback_i;
      end
   end

   // stream reads skip the register stage
   assign read_data_o = (reg_address_i == ADCREAD_ADDR) ? adc_stream_data_i : read_data_reg;

endmodule

//--- verilog/target_pin_arbiter.sv
`timescale 1ns/100ps

module target_pin_arbiter (
   input  logic target_power_off_i,
   input  logic enable_avrprog_i,
   input  logic target_debug_i,
   input  logic target_debug_swd_i,
   input  logic nrst_en_i,
   input  logic nrst_val_i,
   input  logic pdid_en_i,
   input  logic pdid_val_i,
   input  logic pdic_en_i,
   input  logic pdic_val_i,
   input  logic usb_spare0_i,
   input  logic sam_mosi_i,
   input  logic sam_spck_i,
   input  logic target_miso_i,
   input  logic userio_d3_i,
   input  logic userio_d6_i,
   input  logic userio_clk_i,
   output logic target_nrst_o,
   output logic target_nrst_oe_o,
   output logic target_pdid_o,
   output logic target_pdid_oe_o,
   output logic target_pdic_o,
   output logic target_pdic_oe_o,
   output logic target_mosi_o,
   output logic target_mosi_oe_o,
   output logic target_sck_o,
   output logic target_sck_oe_o,
   output logic sam_miso_o,
   output logic sam_miso_oe_o,
   output logic target_poweron_o
);

   logic highz;
   logic swdio_host;

   assign highz      = target_power_off_i;  // never drive an unpowered target
   assign swdio_host = target_debug_i & target_debug_swd_i & ~userio_clk_i;

   // undriven pins park their value at 0
   assign target_pdid_oe_o = ~highz & (swdio_host | pdid_en_i);
   assign target_pdid_o    = highz      ? 1'b0 :
                             swdio_host ? userio_d6_i :
                             pdid_en_i  ? pdid_val_i : 1'b0;

   assign target_pdic_oe_o = ~highz & pdic_en_i;
   assign target_pdic_o    = target_pdic_oe_o & pdic_val_i;

   assign target_nrst_oe_o = ~highz & (enable_avrprog_i | nrst_en_i);
   assign target_nrst_o    = highz            ? 1'b0 :
                             enable_avrprog_i ? usb_spare0_i :
                             nrst_en_i        ? nrst_val_i : 1'b0;

   // SPI lines only for AVR programming
   assign target_mosi_oe_o = ~highz & enable_avrprog_i;
   assign target_mosi_o    = target_mosi_oe_o & sam_mosi_i;
   assign target_sck_oe_o  = ~highz & enable_avrprog_i;
   assign target_sck_o     = target_sck_oe_o & sam_spck_i;

   // MISO back to the SAM ignores target power
   assign sam_miso_oe_o    = target_debug_i | enable_avrprog_i;
   assign sam_miso_o       = target_debug_i   ? userio_d3_i :
                             enable_avrprog_i ? target_miso_i : 1'b0;

   assign target_poweron_o = ~target_power_off_i;

endmodule

//--- verilog/capture_fifo.sv
`timescale 1ns/100ps

module capture_fifo (
   input  logic                               clk_usb_buf,
   input  logic                               reset_i,
   input  logic                               trace_capture_on_i,
   input  logic                               trace_fifo_wr_i,
   input  logic [husky_pkg::FIFO_WORD_W-1:0]  trace_wr_data_i,
   input  logic                               la_fifo_wr_i,
   input  logic [husky_pkg::FIFO_WORD_W-1:0]  la_wr_data_i,
   input  logic                               trace_fifo_flush_i,
   input  logic                               la_fifo_flush_i,
   input  logic                               fifo_read_i,
   input  logic                               clear_errors_i,
   input  logic [husky_pkg::REG_ADDR_W-1:0]   reg_address_i,
   input  logic                               reg_read_i,
   output logic [husky_pkg::FIFO_WORD_W-1:0]  fifo_out_data_o,
   output logic                               fifo_empty_o,
   output logic                               fifo_full_o,
   output logic                               fifo_error_o,
   output logic [husky_pkg::REG_DATA_W-1:0]   readback_o
);
   import husky_pkg::*;

   logic                   src_wr;
   logic [FIFO_WORD_W-1:0] src_data;
   logic                   flush;
   logic                   do_wr;
   logic                   do_rd;
   logic [FIFO_WORD_W-1:0] mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0]  wr_ptr;
   logic [FIFO_PTR_W-1:0]  rd_ptr;
   logic [FIFO_PTR_W:0]    count;
   logic                   overflow;

   // trace owns the FIFO while its capture is on, LA otherwise
   assign src_wr   = trace_capture_on_i ? trace_fifo_wr_i : la_fifo_wr_i;
   assign src_data = trace_capture_on_i ? trace_wr_data_i : la_wr_data_i;
   assign flush    = trace_fifo_flush_i | la_fifo_flush_i;

   assign fifo_empty_o = (count == '0);
   assign fifo_full_o  = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
   assign do_wr        = src_wr & ~fifo_full_o;      // word dropped when full
   assign do_rd        = fifo_read_i & ~fifo_empty_o;

   always_ff @(posedge clk_usb_buf) begin
      if (do_wr) begin
         mem[wr_ptr] <= src_data;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (reset_i || flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;  // idle, or push and pop together
         endcase
      end
   end

   // sticky until software clears it, flush leaves it alone
   always_ff @(posedge clk_usb_buf) begin
      if (reset_i) begin
         overflow <= 1'b0;
      end else if (src_wr && fifo_full_o) begin
         overflow <= 1'b1;
      end else if (clear_errors_i) begin
         overflow <= 1'b0;
      end
   end

   assign fifo_out_data_o = mem[rd_ptr];  // first-word fall-through
   assign fifo_error_o    = overflow;

   always_comb begin
      readback_o = '0;
      if (reg_read_i && (reg_address_i == FIFO_STATUS_ADDR)) begin
         readback_o[FS_EMPTY_BIT]    = fifo_empty_o;
         readback_o[FS_FULL_BIT]     = fifo_full_o;
         readback_o[FS_OVERFLOW_BIT] = overflow;
      end
   end

endmodule

//--- verilog/error_led.sv
`timescale 1ns/100ps

module error_led (
   input  logic clk_usb_buf,
   input  logic reset_i,
   input  logic fifo_error_i,
   input  logic pll_status_i,
   input  logic led_glitch_i,
   output logic led_adc_o,
   output logic led_glitch_o
);
   import husky_pkg::*;

   logic [FLASH_CNT_W-1:0] flash_cnt;
   logic                   flash_pattern;

   // free-running, flips the pattern every half period
   always_ff @(posedge clk_usb_buf) begin
      if (reset_i) begin
         flash_cnt     <= '0;
         flash_pattern <= 1'b0;
      end else if (flash_cnt == FLASH_CNT_W'(FLASH_HALF_PERIOD - 1)) begin
         flash_cnt     <= '0;
         flash_pattern <= ~flash_pattern;
      end else begin
         flash_cnt     <= flash_cnt + 1'b1;
      end
   end

   // fast-flash both red LEDs on an internal error
   assign led_adc_o    = fifo_error_i ? flash_pattern : ~pll_status_i;
   assign led_glitch_o = fifo_error_i ? flash_pattern : led_glitch_i;

endmodule

//--- verilog/husky_glue_top.sv
`timescale 1ns/100ps

module husky_glue_top (
   input  logic                                clk_usb_buf,
   input  logic                                reset_i,

   input  logic [husky_pkg::REG_ADDR_W-1:0]    reg_address_i,
   input  logic [husky_pkg::REG_DATA_W-1:0]    reg_write_data_i,
   input  logic                                reg_read_i,
   input  logic                                reg_write_i,
   output logic [husky_pkg::REG_DATA_W-1:0]    read_data_o,
   input  logic [husky_pkg::REG_DATA_W-1:0]    adc_stream_data_i,

   input  logic                                trace_fifo_wr_i,
   input  logic [husky_pkg::FIFO_WORD_W-1:0]   trace_wr_data_i,
   input  logic                                la_fifo_wr_i,
   input  logic [husky_pkg::FIFO_WORD_W-1:0]   la_wr_data_i,
   input  logic                                trace_fifo_flush_i,
   input  logic                                la_fifo_flush_i,
   input  logic                                fifo_read_i,
   output logic [husky_pkg::FIFO_WORD_W-1:0]   fifo_out_data_o,
   output logic                                fifo_empty_o,
   output logic                                fifo_full_o,

   input  logic                                pll_status_i,
   input  logic                                led_glitch_i,
   output logic                                led_adc_o,
   output logic                                led_glitch_o,

   input  logic                                usb_spare0_i,
   input  logic                                sam_mosi_i,
   input  logic                                sam_spck_i,
   input  logic                                target_miso_i,
   input  logic                                userio_d3_i,
   input  logic                                userio_d6_i,
   input  logic                                userio_clk_i,

   // bidirectional target pins split into value and output enable
   output logic                                target_nrst_o,
   output logic                                target_nrst_oe_o,
   output logic                                target_pdid_o,
   output logic                                target_pdid_oe_o,
   output logic                                target_pdic_o,
   output logic                                target_pdic_oe_o,
   output logic                                target_mosi_o,
   output logic                                target_mosi_oe_o,
   output logic                                target_sck_o,
   output logic                                target_sck_oe_o,
   output logic                                sam_miso_o,
   output logic                                sam_miso_oe_o,
   output logic                                target_poweron_o
);
   import husky_pkg::*;

   logic [REG_DATA_W-1:0] ctrl_readback;
   logic [REG_DATA_W-1:0] fifo_readback;
   logic                  target_power_off;
   logic                  enable_avrprog;
   logic                  target_debug;
   logic                  target_debug_swd;
   logic                  nrst_en;
   logic                  nrst_val;
   logic                  pdid_en;
   logic                  pdid_val;
   logic                  pdic_en;
   logic                  pdic_val;
   logic                  trace_capture_on;
   logic                  clear_errors;
   logic                  fifo_error;

   ctrl_regs u_ctrl_regs (
      .clk_usb_buf        (clk_usb_buf),
      .reset_i            (reset_i),
      .reg_address_i      (reg_address_i),
      .reg_write_data_i   (reg_write_data_i),
      .reg_read_i         (reg_read_i),
      .reg_write_i        (reg_write_i),
      .readback_o         (ctrl_readback),
      .target_power_off_o (target_power_off),
      .enable_avrprog_o   (enable_avrprog),
      .target_debug_o     (target_debug),
      .target_debug_swd_o (target_debug_swd),
      .nrst_en_o          (nrst_en),
      .nrst_val_o         (nrst_val),
      .pdid_en_o          (pdid_en),
      .pdid_val_o         (pdid_val),
      .pdic_en_o          (pdic_en),
      .pdic_val_o         (pdic_val),
      .trace_capture_on_o (trace_capture_on),
      .clear_errors_o     (clear_errors)
   );

   read_data_mux u_read_data_mux (
      .clk_usb_buf        (clk_usb_buf),
      .reset_i            (reset_i),
      .reg_address_i      (reg_address_i),
      .ctrl_readback_i    (ctrl_readback),
      .fifo_readback_i    (fifo_readback),
      .adc_stream_data_i  (adc_stream_data_i),
      .read_data_o        (read_data_o)
   );

   target_pin_arbiter u_target_pin_arbiter (
      .target_power_off_i (target_power_off),
      .enable_avrprog_i   (enable_avrprog),
      .target_debug_i     (target_debug),
      .target_debug_swd_i (target_debug_swd),
      .nrst_en_i          (nrst_en),
      .nrst_val_i         (nrst_val),
      .pdid_en_i          (pdid_en),
      .pdid_val_i         (pdid_val),
      .pdic_en_i          (pdic_en),
      .pdic_val_i         (pdic_val),
      .usb_spare0_i       (usb_spare0_i),
      .sam_mosi_i         (sam_mosi_i),
      .sam_spck_i         (sam_spck_i),
      .target_miso_i      (target_miso_i),
      .userio_d3_i        (userio_d3_i),
      .userio_d6_i        (userio_d6_i),
      .userio_clk_i       (userio_clk_i),
      .target_nrst_o      (target_nrst_o),
      .target_nrst_oe_o   (target_nrst_oe_o),
      .target_pdid_o      (target_pdid_o),
      .target_pdid_oe_o   (target_pdid_oe_o),
      .target_pdic_o      (target_pdic_o),
      .target_pdic_oe_o   (target_pdic_oe_o),
      .target_mosi_o      (target_mosi_o),
      .target_mosi_oe_o   (target_mosi_oe_o),
      .target_sck_o       (target_sck_o),
      .target_sck_oe_o    (target_sck_oe_o),
      .sam_miso_o         (sam_miso_o),
      .sam_miso_oe_o      (sam_miso_oe_o),
      .target_poweron_o   (target_poweron_o)
   );

   capture_fifo u_capture_fifo (
      .clk_usb_buf        (clk_usb_buf),
      .reset_i            (reset_i),
      .trace_capture_on_i (trace_capture_on),
      .trace_fifo_wr_i    (trace_fifo_wr_i),
      .trace_wr_data_i    (trace_wr_data_i),
      .la_fifo_wr_i       (la_fifo_wr_i),
      .la_wr_data_i       (la_wr_data_i),
      .trace_fifo_flush_i (trace_fifo_flush_i),
      .la_fifo_flush_i    (la_fifo_flush_i),
      .fifo_read_i        (fifo_read_i),
      .clear_errors_i     (clear_errors),
      .reg_address_i      (reg_address_i),
      .reg_read_i         (reg_read_i),
      .fifo_out_data_o    (fifo_out_data_o),
      .fifo_empty_o       (fifo_empty_o),
      .fifo_full_o        (fifo_full_o),
      .fifo_error_o       (fifo_error),
      .readback_o         (fifo_readback)
   );

   error_led u_error_led (
      .clk_usb_buf        (clk_usb_buf),
      .reset_i            (reset_i),
      .fifo_error_i       (fifo_error),
      .pll_status_i       (pll_status_i),
      .led_glitch_i       (led_glitch_i),
      .led_adc_o          (led_adc_o),
      .led_glitch_o       (led_glitch_o)
   );

endmodule

//--- verif/capture_fifo_checker.sv
`timescale 1ns/100ps

module capture_fifo_checker (
   input logic                              clk_usb_buf,
   input logic                              reset_i,
   input logic                              fifo_empty_i,
   input logic                              fifo_full_i,
   input logic [husky_pkg::FIFO_PTR_W:0]    count_i,
   input logic [husky_pkg::FIFO_PTR_W-1:0]  wr_ptr_i,
   input logic [husky_pkg::FIFO_PTR_W-1:0]  rd_ptr_i,
   input logic                              overflow_i,
   input logic                              clear_errors_i
);
   import husky_pkg::*;

   // equal pointers mean either no word stored or a full wrap
   a_empty_full: assert property (@(posedge clk_usb_buf) disable iff (reset_i)
      !(fifo_empty_i && fifo_full_i) &&
      ((fifo_empty_i || fifo_full_i) == (wr_ptr_i == rd_ptr_i)))
      else $error("FIFO empty and full flags disagree with the pointers");

   a_count_bound: assert property (@(posedge clk_usb_buf) disable iff (reset_i)
      count_i <= (FIFO_PTR_W + 1)'(FIFO_DEPTH))
      else $error("FIFO count above its depth");

   // sticky error only drops after a clear pulse
   a_overflow_sticky: assert property (@(posedge clk_usb_buf) disable iff (reset_i)
      $fell(overflow_i) |-> $past(clear_errors_i))
      else $error("overflow error dropped without a clear pulse");

endmodule

bind capture_fifo capture_fifo_checker i_fifo_chk (
   .clk_usb_buf    (clk_usb_buf),
   .reset_i        (reset_i),
   .fifo_empty_i   (fifo_empty_o),
   .fifo_full_i    (fifo_full_o),
   .count_i        (count),
   .wr_ptr_i       (wr_ptr),
   .rd_ptr_i       (rd_ptr),
   .overflow_i     (overflow),
   .clear_errors_i (clear_errors_i)
);

//--- verif/tb_husky_glue.sv
`timescale 1ns/100ps

module tb_husky_glue;
   import husky_pkg::*;

   // trace opcodes
   localparam int OP_REG_WR     = 'h1;
   localparam int OP_REG_RD     = 'h2;
   localparam int OP_PINS       = 'h3;
   localparam int OP_TRACE_WORD = 'h4;
   localparam int OP_LA_WORD    = 'h5;
   localparam int OP_POP        = 'h6;
   localparam int OP_FLUSH      = 'h7;
   localparam int OP_OVERFLOW   = 'h8;
   localparam int OP_FLASH      = 'h9;
   localparam int OP_LED_IDLE   = 'ha;
   localparam int OP_STREAM     = 'hb;
   localparam int LINE_LIMIT    = 1000;

   logic                   clk_usb_buf;
   logic                   reset_i;
   logic [REG_ADDR_W-1:0]  reg_address_i;
   logic [REG_DATA_W-1:0]  reg_write_data_i;
   logic                   reg_read_i;
   logic                   reg_write_i;
   logic [REG_DATA_W-1:0]  read_data_o;
   logic [REG_DATA_W-1:0]  adc_stream_data_i;
   logic                   trace_fifo_wr_i;
   logic [FIFO_WORD_W-1:0] trace_wr_data_i;
   logic                   la_fifo_wr_i;
   logic [FIFO_WORD_W-1:0] la_wr_data_i;
   logic                   trace_fifo_flush_i;
   logic                   la_fifo_flush_i;
   logic                   fifo_read_i;
   logic [FIFO_WORD_W-1:0] fifo_out_data_o;
   logic                   fifo_empty_o;
   logic                   fifo_full_o;
   logic                   pll_status_i;
   logic                   led_glitch_i;
   logic                   led_adc_o;
   logic                   led_glitch_o;
   logic                   usb_spare0_i;
   logic                   sam_mosi_i;
   logic                   sam_spck_i;
   logic                   target_miso_i;
   logic                   userio_d3_i;
   logic                   userio_d6_i;
   logic                   userio_clk_i;
   logic                   target_nrst_o;
   logic                   target_nrst_oe_o;
   logic                   target_pdid_o;
   logic                   target_pdid_oe_o;
   logic                   target_pdic_o;
   logic                   target_pdic_oe_o;
   logic                   target_mosi_o;
   logic                   target_mosi_oe_o;
   logic                   target_sck_o;
   logic                   target_sck_oe_o;
   logic                   sam_miso_o;
   logic                   sam_miso_oe_o;
   logic                   target_poweron_o;

   int                     errors;
   int                     checks;
   logic [31:0]            rng_state;
   logic [FIFO_WORD_W-1:0] model_q[$];  // expected pop order of the overflow fill

   husky_glue_top i_dut (.*);

   initial begin
      clk_usb_buf = 1'b0;
      forever #2 clk_usb_buf = ~clk_usb_buf;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic expect_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // value only matters while the pin is driven
   task automatic expect_pin(input string name, input logic oe, input logic val,
                             input logic [1:0] exp);
      expect_equal({name, "_oe_o"}, oe, exp[1]);
      if (exp[1]) begin
         expect_equal({name, "_o"}, val, exp[0]);
      end
   endtask

   task automatic apply_pins(input logic [31:0] pins_in, input logic [31:0] exp);
      {usb_spare0_i, sam_mosi_i, sam_spck_i, target_miso_i,
       userio_d3_i, userio_d6_i, userio_clk_i} = pins_in[6:0];
      #1;  // arbiter is combinational
      expect_equal("target_poweron_o", target_poweron_o, exp[12]);
      expect_pin("target_nrst", target_nrst_oe_o, target_nrst_o, exp[11:10]);
      expect_pin("target_pdid", target_pdid_oe_o, target_pdid_o, exp[9:8]);
      expect_pin("target_pdic", target_pdic_oe_o, target_pdic_o, exp[7:6]);
      expect_pin("target_mosi", target_mosi_oe_o, target_mosi_o, exp[5:4]);
      expect_pin("target_sck", target_sck_oe_o, target_sck_o, exp[3:2]);
      expect_pin("sam_miso", sam_miso_oe_o, sam_miso_o, exp[1:0]);
      @(negedge clk_usb_buf);
   endtask

   task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
      reg_address_i    = addr[REG_ADDR_W-1:0];
      reg_write_data_i = data[REG_DATA_W-1:0];
      reg_write_i      = 1'b1;
      @(negedge clk_usb_buf);
      reg_write_i      = 1'b0;
   endtask

   task automatic reg_read(input logic [31:0] addr, input logic [31:0] exp);
      reg_address_i = addr[REG_ADDR_W-1:0];
      reg_read_i    = 1'b1;
      @(negedge clk_usb_buf);  // one cycle read latency
      expect_equal("read_data_o", read_data_o, exp);
      reg_read_i    = 1'b0;
   endtask

   task automatic push_word(input bit from_la, input logic [31:0] data);
      if (from_la) begin
         la_fifo_wr_i = 1'b1;
         la_wr_data_i = data[FIFO_WORD_W-1:0];
      end else begin
         trace_fifo_wr_i = 1'b1;
         trace_wr_data_i = data[FIFO_WORD_W-1:0];
      end
      @(negedge clk_usb_buf);
      la_fifo_wr_i    = 1'b0;
      trace_fifo_wr_i = 1'b0;
   endtask

   task automatic pop_word(input logic [31:0] exp);
      expect_equal("fifo_empty_o", fifo_empty_o, 0);
      expect_equal("fifo_out_data_o", fifo_out_data_o, exp);
      fifo_read_i = 1'b1;
      @(negedge clk_usb_buf);
      fifo_read_i = 1'b0;
   endtask

   task automatic flush_fifo(input bit from_la);
      if (from_la) begin
         la_fifo_flush_i = 1'b1;
      end else begin
         trace_fifo_flush_i = 1'b1;
      end
      @(negedge clk_usb_buf);
      la_fifo_flush_i    = 1'b0;
      trace_fifo_flush_i = 1'b0;
      expect_equal("fifo_empty_o", fifo_empty_o, 1);
   endtask

   // one word more than fits goes through the trace writer
   task automatic fill_overflow();
      logic [FIFO_WORD_W-1:0] word;
      model_q.delete();
      for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
         rng_state = xorshift(rng_state);
         word      = rng_state[FIFO_WORD_W-1:0];
         if (model_q.size() < FIFO_DEPTH) begin
            model_q.push_back(word);  // last one is discarded
         end
         trace_fifo_wr_i = 1'b1;
         trace_wr_data_i = word;
         @(negedge clk_usb_buf);
      end
      trace_fifo_wr_i = 1'b0;
      expect_equal("fifo_full_o", fifo_full_o, 1);
      reg_read(FIFO_STATUS_ADDR, (1 << FS_FULL_BIT) | (1 << FS_OVERFLOW_BIT));
      while (model_q.size() > 0) begin
         pop_word(model_q.pop_front());
      end
      expect_equal("fifo_empty_o", fifo_empty_o, 1);
   endtask

   task automatic watch_flash();
      logic adc_start;
      logic glitch_start;
      bit   adc_moved;
      bit   glitch_moved;
      int   cycles;
      adc_start    = led_adc_o;
      glitch_start = led_glitch_o;
      adc_moved    = 1'b0;
      glitch_moved = 1'b0;
      cycles       = 0;
      while (!(adc_moved && glitch_moved) && cycles < 4 * FLASH_HALF_PERIOD) begin
         @(negedge clk_usb_buf);
         cycles++;
         adc_moved    = adc_moved | (led_adc_o !== adc_start);
         glitch_moved = glitch_moved | (led_glitch_o !== glitch_start);
      end
      checks++;
      assert (adc_moved && glitch_moved) else begin
         $display("timeout at %0t: red LEDs did not flash within %0d cycles of an error",
                  $time, 4 * FLASH_HALF_PERIOD);
         errors++;
      end
   endtask

   // no error, so the LEDs must stay on their normal sources
   task automatic watch_led_idle(input logic pll, input logic glitch);
      logic exp_adc;
      exp_adc      = ~pll;
      pll_status_i = pll;
      led_glitch_i = glitch;
      for (int i = 0; i < 2 * FLASH_HALF_PERIOD; i++) begin
         #1;
         expect_equal("led_adc_o", led_adc_o, exp_adc);
         expect_equal("led_glitch_o", led_glitch_o, glitch);
         @(negedge clk_usb_buf);
      end
   endtask

   task automatic stream_read(input logic [31:0] val);
      reg_address_i     = ADCREAD_ADDR;
      reg_read_i        = 1'b1;
      adc_stream_data_i = val[REG_DATA_W-1:0];
      #1;  // no register stage on the stream path
      expect_equal("read_data_o", read_data_o, val);
      @(negedge clk_usb_buf);
      reg_read_i        = 1'b0;
   endtask

   task automatic run_trace();
      int                fd;
      int                lines;
      logic [8*96-1:0]   text;
      logic [31:0]       op;
      logic [31:0]       a;
      logic [31:0]       b;
      fd = $fopen("verif/husky_glue_trace.txt", "r");
      if (fd == 0) begin
         $display("could not open the trace file verif/husky_glue_trace.txt");
         errors++;
         return;
      end
      lines = 0;
      while (!$feof(fd) && lines < LINE_LIMIT) begin
         lines++;
         text = '0;
         void'($fgets(text, fd));
         if ($sscanf(text, "%h %h %h", op, a, b) == 3) begin  // comments fail the scan
            case (op)
               OP_REG_WR:     reg_write(a, b);
               OP_REG_RD:     reg_read(a, b);
               OP_PINS:       apply_pins(a, b);
               OP_TRACE_WORD: push_word(1'b0, a);
               OP_LA_WORD:    push_word(1'b1, a);
               OP_POP:        pop_word(a);
               OP_FLUSH:      flush_fifo(a[0]);
               OP_OVERFLOW:   fill_overflow();
               OP_FLASH:      watch_flash();
               OP_LED_IDLE:   watch_led_idle(a[0], b[0]);
               OP_STREAM:     stream_read(a);
               default: begin
                  $display("unknown opcode %h on trace line %0d", op, lines);
                  errors++;
               end
            endcase
         end
      end
      $fclose(fd);
   endtask

   initial begin
      errors             = 0;
      checks             = 0;
      rng_state          = 32'h9e07;
      reset_i            = 1'b1;
      reg_address_i      = '0;
      reg_write_data_i   = '0;
      reg_read_i         = 1'b0;
      reg_write_i        = 1'b0;
      adc_stream_data_i  = '0;
      trace_fifo_wr_i    = 1'b0;
      trace_wr_data_i    = '0;
      la_fifo_wr_i       = 1'b0;
      la_wr_data_i       = '0;
      trace_fifo_flush_i = 1'b0;
      la_fifo_flush_i    = 1'b0;
      fifo_read_i        = 1'b0;
      pll_status_i       = 1'b1;
      led_glitch_i       = 1'b0;
      {usb_spare0_i, sam_mosi_i, sam_spck_i, target_miso_i,
       userio_d3_i, userio_d6_i, userio_clk_i} = '0;
      repeat (16) @(posedge clk_usb_buf);  // reset seen on 16 rising edges
      @(negedge clk_usb_buf);
      reset_i = 1'b0;
      run_trace();
      repeat (2) @(negedge clk_usb_buf);
      $display("summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0 && checks > 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- verif/husky_glue_trace.txt
# op a b: 1 write addr data, 2 read addr expected, 3 pins inputs[6:0] expected[12:0]
# 4 trace word, 5 LA word, 6 pop expected, 7 flush src, 8 overflow, 9 flash, a idle pll glitch, b stream
2 07 01
3 7f 0000
2 04 01
2 02 00
1 05 3f
2 05 3f
3 7f 0000
1 04 00
3 00 1fc0
1 04 02
2 04 02
3 68 1ffb
1 04 0c
3 06 1fc3
1 05 04
3 03 1202
1 04 0d
3 04 0003
1 06 01
2 06 01
4 12345 0
5 3ffff 0
4 00abc 0
6 12345 0
6 00abc 0
2 07 01
1 06 00
5 2aaaa 0
4 15555 0
5 00001 0
6 2aaaa 0
6 00001 0
5 11111 0
7 0 0
5 22222 0
7 1 0
1 06 01
8 0 0
9 0 0
1 06 03
2 06 01
2 07 01
a 1 0
a 0 1
b 5a 0
b a5 0
b 00 0
b ff 0

//--- flist.f
verilog/husky_pkg.sv
verilog/ctrl_regs.sv
verilog/read_data_mux.sv
verilog/target_pin_arbiter.sv
verilog/capture_fifo.sv
verilog/error_led.sv
verilog/husky_glue_top.sv
verif/capture_fifo_checker.sv
verif/tb_husky_glue.sv

//--- Makefile
SIM   = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_husky_glue
FLIST = flist.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
